// ==== source/mem_rsp_buffer.sv ====
//==============================
// Memory-side interposer for the metadata shim
// Both response channels always see exactly one cycle of delay
// Request channels and almost-full are wires or one register stage
// No back-pressure exists on responses, so nothing here can stall
//==============================

`timescale 1ns/1ps
`default_nettype none

module mem_rsp_buffer
#(
    // Nonzero puts one register stage on the request channels and almost-full
    parameter int register_outbound = 0
)
(
    input  wire                        clk,
    input  wire                        reset,

    // Request side, from the shim toward memory
    input  mem_shim_pkg::mem_rd_req_t  req_rd_in,
    input  mem_shim_pkg::wr_req_t      req_wr_in,
    output mem_shim_pkg::mem_rd_req_t  req_rd_out,
    output mem_shim_pkg::wr_req_t      req_wr_out,

    // Response side, from memory back toward the shim
    input  mem_shim_pkg::mem_rd_rsp_t  rsp_rd_in,
    input  mem_shim_pkg::wr_rsp_t      rsp_wr_in,
    output mem_shim_pkg::mem_rd_rsp_t  rsp_rd_out,
    output mem_shim_pkg::wr_rsp_t      rsp_wr_out,

    // Advisory flow control level from memory
    input  wire                        almost_full_in,
    output logic                       almost_full_out
);

    // The outbound path is chosen at elaboration time
    generate
        if (register_outbound == 0)
        begin : g_outbound_wire
            // Same-cycle pass through toward memory
            assign req_rd_out      = req_rd_in;
            assign req_wr_out      = req_wr_in;
            assign almost_full_out = almost_full_in;
        end
        else
        begin : g_outbound_reg
            always_ff @(posedge clk)
            begin
                // Payload fields follow the input every cycle
                req_rd_out      <= req_rd_in;
                req_wr_out      <= req_wr_in;
                almost_full_out <= almost_full_in;

                // Reset clears the request strobes and the registered level
                if (reset)
                begin
                    req_rd_out.valid <= 1'b0;
                    req_wr_out.valid <= 1'b0;
                    almost_full_out  <= 1'b0;
                end
            end
        end
    endgenerate

    // Responses always spend one cycle here, which gives the RAM lookup
    // started on rsp_rd_in time to finish before rsp_rd_out leaves
    always_ff @(posedge clk)
    begin
        rsp_rd_out <= rsp_rd_in;
        rsp_wr_out <= rsp_wr_in;

        if (reset)
        begin
            rsp_rd_out.valid <= 1'b0;
            rsp_wr_out.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== source/mem_shim_pkg.sv ====
//==============================
// Widths and channel structs for the memory response shim
// Every channel carries its own valid bit as a one-cycle strobe
// There is no ready signal on any channel
// Tag width sets the metadata RAM depth to 2**tag_bits entries
//==============================

`default_nettype none

package mem_shim_pkg;

    // Address carried by read and write requests
    localparam int addr_bits = 32;

    // Data width of write requests and read responses
    localparam int data_bits = 64;

    // Tag width, which gives 64 outstanding tags
    localparam int tag_bits = 6;

    // Metadata word the AFU attaches to each read request
    localparam int meta_bits = 16;

    // Read request as issued by the AFU, metadata included
    typedef struct packed {
        logic                 valid;
        logic [addr_bits-1:0] addr;
        logic [tag_bits-1:0]  tag;
        logic [meta_bits-1:0] meta;
    } afu_rd_req_t;

    // Read request toward memory once the metadata has been stripped
    typedef struct packed {
        logic                 valid;
        logic [addr_bits-1:0] addr;
        logic [tag_bits-1:0]  tag;
    } mem_rd_req_t;

    // Write request, identical on the AFU and memory sides
    typedef struct packed {
        logic                 valid;
        logic [addr_bits-1:0] addr;
        logic [tag_bits-1:0]  tag;
        logic [data_bits-1:0] data;
    } wr_req_t;

    // Read response as returned by memory
    typedef struct packed {
        logic                 valid;
        logic [tag_bits-1:0]  tag;
        logic [data_bits-1:0] data;
    } mem_rd_rsp_t;

    // Read response toward the AFU with the metadata put back
    typedef struct packed {
        logic                 valid;
        logic [tag_bits-1:0]  tag;
        logic [data_bits-1:0] data;
        logic [meta_bits-1:0] meta;
    } afu_rd_rsp_t;

    // Write acknowledgement, identical on both sides
    typedef struct packed {
        logic                valid;
        logic [tag_bits-1:0] tag;
    } wr_rsp_t;

endpackage

`default_nettype wire

// ==== source/mem_shim_top.sv ====
//==============================
// Top level of the memory response metadata shim
// With register_outbound at 0, requests and almost-full are same-cycle
// With register_outbound at 1, they take one cycle
// Read and write responses always take one cycle
// Almost-full is advisory and the shim never drops a request
//==============================

`timescale 1ns/1ps
`default_nettype none

module mem_shim_top
#(
    // Selects one register stage on the paths toward memory
    parameter int register_outbound = 0
)
(
    input  wire                        clk,
    input  wire                        reset,

    // Requests from the AFU
    input  mem_shim_pkg::afu_rd_req_t  afu_rd_req,
    input  mem_shim_pkg::wr_req_t      afu_wr_req,

    // Responses and flow control from memory
    input  mem_shim_pkg::mem_rd_rsp_t  mem_rd_rsp,
    input  mem_shim_pkg::wr_rsp_t      mem_wr_rsp,
    input  wire                        mem_almost_full,

    // Requests toward memory
    output mem_shim_pkg::mem_rd_req_t  mem_rd_req,
    output mem_shim_pkg::wr_req_t      mem_wr_req,

    // Responses and flow control toward the AFU
    output mem_shim_pkg::afu_rd_rsp_t  afu_rd_rsp,
    output mem_shim_pkg::wr_rsp_t      afu_wr_rsp,
    output logic                       afu_almost_full
);

    // The whole datapath lives in the shim below
    rsp_meta_shim
    #(
        .register_outbound (register_outbound)
    )
    rsp_meta_shim_inst
    (
        .clk             (clk),
        .reset           (reset),
        .afu_rd_req      (afu_rd_req),
        .afu_wr_req      (afu_wr_req),
        .afu_rd_rsp      (afu_rd_rsp),
        .afu_wr_rsp      (afu_wr_rsp),
        .afu_almost_full (afu_almost_full),
        .mem_rd_req      (mem_rd_req),
        .mem_wr_req      (mem_wr_req),
        .mem_rd_rsp      (mem_rd_rsp),
        .mem_wr_rsp      (mem_wr_rsp),
        .mem_almost_full (mem_almost_full)
    );

endmodule

`default_nettype wire

// ==== source/rsp_meta_shim.sv ====
//==============================
// Metadata shim for the read channel
// Read request meta is stored by tag and stripped before memory
// The response tag starts a RAM read while the response is buffered
// The stored meta joins the response as it leaves the buffer
// A tag's request must be issued before its response arrives
// Tag uniqueness is not checked and responses are not reordered
//==============================

`timescale 1ns/1ps
`default_nettype none

module rsp_meta_shim
#(
    // Passed down to the buffer to pick wires or a register stage outbound
    parameter int register_outbound = 0
)
(
    input  wire                        clk,
    input  wire                        reset,

    // AFU side
    input  mem_shim_pkg::afu_rd_req_t  afu_rd_req,
    input  mem_shim_pkg::wr_req_t      afu_wr_req,
    output mem_shim_pkg::afu_rd_rsp_t  afu_rd_rsp,
    output mem_shim_pkg::wr_rsp_t      afu_wr_rsp,
    output logic                       afu_almost_full,

    // Memory side
    output mem_shim_pkg::mem_rd_req_t  mem_rd_req,
    output mem_shim_pkg::wr_req_t      mem_wr_req,
    input  mem_shim_pkg::mem_rd_rsp_t  mem_rd_rsp,
    input  mem_shim_pkg::wr_rsp_t      mem_wr_rsp,
    input  wire                        mem_almost_full
);

    // Read request with the meta field removed
    mem_shim_pkg::mem_rd_req_t rd_req_stripped;

    // Read response after its one cycle in the buffer
    mem_shim_pkg::mem_rd_rsp_t rd_rsp_buf;

    // Metadata looked up for the response now leaving the buffer
    logic [mem_shim_pkg::meta_bits-1:0] rsp_meta;

    // Copy everything but the meta into the memory-bound request
    always_comb
    begin
        rd_req_stripped.valid = afu_rd_req.valid;
        rd_req_stripped.addr  = afu_rd_req.addr;
        rd_req_stripped.tag   = afu_rd_req.tag;
    end

    // Meta is written at issue time, which is always before memory can
    // answer, even with the outbound register stage enabled
    // The read side is addressed by the raw, unbuffered response tag
    tag_meta_ram tag_meta_ram_inst
    (
        .clk     (clk),
        .wr_en   (afu_rd_req.valid),
        .wr_tag  (afu_rd_req.tag),
        .wr_meta (afu_rd_req.meta),
        .rd_tag  (mem_rd_rsp.tag),
        .rd_meta (rsp_meta)
    );

    // Interposer on the memory side of the shim
    mem_rsp_buffer
    #(
        .register_outbound (register_outbound)
    )
    mem_rsp_buffer_inst
    (
        .clk             (clk),
        .reset           (reset),
        .req_rd_in       (rd_req_stripped),
        .req_wr_in       (afu_wr_req),
        .req_rd_out      (mem_rd_req),
        .req_wr_out      (mem_wr_req),
        .rsp_rd_in       (mem_rd_rsp),
        .rsp_wr_in       (mem_wr_rsp),
        .rsp_rd_out      (rd_rsp_buf),
        .rsp_wr_out      (afu_wr_rsp),
        .almost_full_in  (mem_almost_full),
        .almost_full_out (afu_almost_full)
    );

    // RAM output and buffered response line up on the same cycle
    always_comb
    begin
        afu_rd_rsp.valid = rd_rsp_buf.valid;
        afu_rd_rsp.tag   = rd_rsp_buf.tag;
        afu_rd_rsp.data  = rd_rsp_buf.data;
        afu_rd_rsp.meta  = rsp_meta;
    end

endmodule

`default_nettype wire

// ==== source/tag_meta_ram.sv ====
//==============================
// One metadata word per tag in a simple dual-port RAM
// Read data is registered and appears one cycle after rd_tag
// A same-cycle write and read of one tag returns the old word
// Contents are not cleared by reset
//==============================

`timescale 1ns/1ps
`default_nettype none

module tag_meta_ram
(
    input  wire                                    clk,

    // Write port, driven when a read request is issued
    input  wire                                    wr_en,
    input  wire [mem_shim_pkg::tag_bits-1:0]       wr_tag,
    input  wire [mem_shim_pkg::meta_bits-1:0]      wr_meta,

    // Read port, addressed by the tag of an arriving response
    input  wire [mem_shim_pkg::tag_bits-1:0]       rd_tag,
    output logic [mem_shim_pkg::meta_bits-1:0]     rd_meta
);

    // Number of entries, one per possible tag
    localparam int depth = 2 ** mem_shim_pkg::tag_bits;

    // Storage array, meant to map onto block RAM
    logic [mem_shim_pkg::meta_bits-1:0] meta_mem [depth];

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            meta_mem[wr_tag] <= wr_meta;
        end

        // The read runs every cycle; the nonblocking update above means a
        // colliding read sees the word from before this edge
        rd_meta <= meta_mem[rd_tag];
    end

endmodule

`default_nettype wire

// ==== test/mem_shim_tb.sv ====
//==============================
// Table-driven testbench for the memory response metadata shim
// Runs with register_outbound at 0, so requests are same-cycle
// One table row is applied per clock and outputs are sampled at negedge
// Read response rows must come after the read request for the same tag
// Read response data comes from an LCG with a fixed seed
//==============================

`timescale 1ns/1ps
`default_nettype none

module mem_shim_tb;

    // Row operations
    localparam logic [2:0] op_rd_req = 3'd0;
    localparam logic [2:0] op_wr_req = 3'd1;
    localparam logic [2:0] op_rd_rsp = 3'd2;
    localparam logic [2:0] op_wr_rsp = 3'd3;
    localparam logic [2:0] op_af     = 3'd4;
    localparam logic [2:0] op_idle   = 3'd5;
    localparam int reset_cycles = 16;

    typedef struct packed {
        logic [2:0]                          op;
        logic [mem_shim_pkg::addr_bits-1:0]  addr;
        logic [mem_shim_pkg::tag_bits-1:0]   tag;
        logic [mem_shim_pkg::meta_bits-1:0]  meta;
        logic [mem_shim_pkg::data_bits-1:0]  data;
    } row_t;

    logic clk;
    logic reset;
    mem_shim_pkg::afu_rd_req_t afu_rd_req;
    mem_shim_pkg::wr_req_t     afu_wr_req;
    mem_shim_pkg::mem_rd_rsp_t mem_rd_rsp;
    mem_shim_pkg::wr_rsp_t     mem_wr_rsp;
    logic                      mem_almost_full;
    mem_shim_pkg::mem_rd_req_t mem_rd_req;
    mem_shim_pkg::wr_req_t     mem_wr_req;
    mem_shim_pkg::afu_rd_rsp_t afu_rd_rsp;
    mem_shim_pkg::wr_rsp_t     afu_wr_rsp;
    logic                      afu_almost_full;

    row_t        rows[$];
    logic [31:0] rand_state = 32'h87efe096;
    logic        table_ready = 1'b0;
    int          timeout_limit;
    int          cycle_count;

    // Scoreboard with meta per tag and one pending response per channel
    logic [mem_shim_pkg::meta_bits-1:0] exp_meta [64];
    mem_shim_pkg::afu_rd_rsp_t exp_rd = '0;
    mem_shim_pkg::wr_rsp_t     exp_wr = '0;
    logic                      af_level = 1'b0;

    mem_shim_top #(.register_outbound (0)) mem_shim_top_inst
    (
        .clk (clk), .reset (reset),
        .afu_rd_req (afu_rd_req), .afu_wr_req (afu_wr_req),
        .mem_rd_rsp (mem_rd_rsp), .mem_wr_rsp (mem_wr_rsp),
        .mem_almost_full (mem_almost_full),
        .mem_rd_req (mem_rd_req), .mem_wr_req (mem_wr_req),
        .afu_rd_rsp (afu_rd_rsp), .afu_wr_rsp (afu_wr_rsp),
        .afu_almost_full (afu_almost_full)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic require(input logic ok, input string what);
        assert (ok)
        else
        begin
            $display("Error at %0t ns: %s", $time, what);
            $display("** FAIL **");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // Read response rows get fresh LCG data, stored in the row as expected data
    task automatic add_row(input logic [2:0] op, input logic [31:0] addr,
                           input logic [5:0] tag, input logic [15:0] meta,
                           input logic [63:0] data);
        row_t r;
        r = '{op: op, addr: addr, tag: tag, meta: meta, data: data};
        if (op == op_rd_rsp)
        begin
            rand_state = lcg_next(rand_state);
            r.data[63:32] = rand_state;
            rand_state = lcg_next(rand_state);
            r.data[31:0] = rand_state;
        end
        rows.push_back(r);
    endtask

    task automatic build_table();
        add_row(op_rd_req, 32'h0000_1000, 6'd3, 16'h1111, '0);
        add_row(op_rd_req, 32'h0000_1040, 6'd7, 16'h2222, '0);
        add_row(op_wr_req, 32'h0000_2000, 6'd9, '0, 64'hdead_beef_0123_4567);
        add_row(op_rd_req, 32'h0000_1080, 6'd12, 16'h3333, '0);
        // Three responses back to back, all in flight together
        add_row(op_rd_rsp, '0, 6'd3, '0, '0);
        add_row(op_rd_rsp, '0, 6'd7, '0, '0);
        add_row(op_rd_rsp, '0, 6'd12, '0, '0);
        add_row(op_wr_rsp, '0, 6'd9, '0, '0);
        add_row(op_af, '0, '0, '0, 64'd1);
        // Tag 3 reused with new meta
        add_row(op_rd_req, 32'h0000_3000, 6'd3, 16'haaaa, '0);
        add_row(op_af, '0, '0, '0, 64'd0);
        add_row(op_rd_rsp, '0, 6'd3, '0, '0);
        add_row(op_wr_req, 32'hffff_fff8, 6'd20, '0, 64'h0f0f_1234_5678_9abc);
        add_row(op_wr_rsp, '0, 6'd20, '0, '0);
        add_row(op_rd_req, 32'h8000_0000, 6'd63, 16'hbeef, '0);
        add_row(op_rd_rsp, '0, 6'd63, '0, '0);
        add_row(op_wr_rsp, '0, 6'd0, '0, '0);
        add_row(op_af, '0, '0, '0, 64'd1);
        add_row(op_af, '0, '0, '0, 64'd0);
        add_row(op_idle, '0, '0, '0, '0);
    endtask

    // Each row raises at most one strobe, and the almost-full level persists
    task automatic apply_row(input row_t r);
        mem_shim_pkg::afu_rd_req_t rd_req;
        mem_shim_pkg::wr_req_t     wr_req;
        mem_shim_pkg::mem_rd_rsp_t rd_rsp;
        mem_shim_pkg::wr_rsp_t     wr_rsp;
        rd_req = '{valid: r.op == op_rd_req, addr: r.addr, tag: r.tag, meta: r.meta};
        wr_req = '{valid: r.op == op_wr_req, addr: r.addr, tag: r.tag, data: r.data};
        rd_rsp = '{valid: r.op == op_rd_rsp, tag: r.tag, data: r.data};
        wr_rsp = '{valid: r.op == op_wr_rsp, tag: r.tag};
        if (r.op == op_af)
            af_level = r.data[0];
        afu_rd_req      <= rd_req;
        afu_wr_req      <= wr_req;
        mem_rd_rsp      <= rd_rsp;
        mem_wr_rsp      <= wr_rsp;
        mem_almost_full <= af_level;
    endtask

    // Requests and almost-full pass straight through in the same cycle
    task automatic verify_outbound(input row_t r);
        require(mem_rd_req.valid == (r.op == op_rd_req), "mem_rd_req valid wrong");
        if (r.op == op_rd_req)
            require(mem_rd_req.addr == r.addr && mem_rd_req.tag == r.tag,
                    $sformatf("mem_rd_req addr %h tag %0d", mem_rd_req.addr, mem_rd_req.tag));
        require(mem_wr_req.valid == (r.op == op_wr_req), "mem_wr_req valid wrong");
        if (r.op == op_wr_req)
            require(mem_wr_req.addr == r.addr && mem_wr_req.tag == r.tag
                    && mem_wr_req.data == r.data, "mem_wr_req body differs from request");
        require(afu_almost_full == af_level,
                $sformatf("afu_almost_full %b, expected %b", afu_almost_full, af_level));
    endtask

    // Responses are compared with what the previous row put in flight
    task automatic compare_responses();
        require(afu_rd_rsp.valid == exp_rd.valid, "afu_rd_rsp valid wrong");
        if (exp_rd.valid)
            require(afu_rd_rsp == exp_rd,
                    $sformatf("afu_rd_rsp tag %0d meta %h, expected tag %0d meta %h",
                              afu_rd_rsp.tag, afu_rd_rsp.meta, exp_rd.tag, exp_rd.meta));
        require(afu_wr_rsp == exp_wr,
                $sformatf("afu_wr_rsp %b/%0d, expected %b/%0d", afu_wr_rsp.valid,
                          afu_wr_rsp.tag, exp_wr.valid, exp_wr.tag));
    endtask

    // A response carries the meta of the latest earlier request for its tag
    task automatic record_row(input row_t r);
        if (r.op == op_rd_req)
            exp_meta[r.tag] = r.meta;
        exp_rd = '{valid: r.op == op_rd_rsp, tag: r.tag, data: r.data, meta: exp_meta[r.tag]};
        exp_wr = '{valid: r.op == op_wr_rsp, tag: r.tag};
    endtask

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Watchdog over the whole run
    initial
    begin
        cycle_count = 0;
        wait (table_ready);
        while (cycle_count < timeout_limit)
        begin
            @(posedge clk);
            cycle_count = cycle_count + 1;
        end
        $display("Timeout: the table did not finish within %0d cycles", timeout_limit);
        $display("** FAIL **");
        $fatal(1, "Run stopped by the cycle limit");
    end

    initial
    begin
        reset = 1'b1;
        afu_rd_req = '0;
        afu_wr_req = '0;
        mem_rd_rsp = '0;
        mem_wr_rsp = '0;
        // Response strobes held high through reset must not reach the AFU
        mem_rd_rsp.valid = 1'b1;
        mem_wr_rsp.valid = 1'b1;
        mem_almost_full = 1'b0;
        build_table();
        timeout_limit = reset_cycles + rows.size() + 10;
        table_ready = 1'b1;

        // Every valid output stays low through reset
        for (int c = 0; c < reset_cycles; c++)
        begin
            @(posedge clk);
            if (c == reset_cycles - 1)
            begin
                reset      <= 1'b0;
                mem_rd_rsp <= '0;
                mem_wr_rsp <= '0;
            end
            @(negedge clk);
            require(!afu_rd_rsp.valid && !afu_wr_rsp.valid && !mem_rd_req.valid
                    && !mem_wr_req.valid && !afu_almost_full, "valid output set in reset");
        end

        foreach (rows[i])
        begin
            @(posedge clk);
            apply_row(rows[i]);
            @(negedge clk);
            verify_outbound(rows[i]);
            compare_responses();
            record_row(rows[i]);
        end

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
source/mem_shim_pkg.sv
source/tag_meta_ram.sv
source/mem_rsp_buffer.sv
source/rsp_meta_shim.sv
source/mem_shim_top.sv
test/mem_shim_tb.sv
